// File: rtl/sys_pkg.sv
`default_nettype none

package sys_pkg;

    localparam int SAMPLE_WIDTH   = 16;
    localparam int BATCH_SAMPLES  = 4;
    localparam int BATCH_WIDTH    = SAMPLE_WIDTH * BATCH_SAMPLES;
    localparam int REG_DATA_WIDTH = 32;
    localparam int REG_COUNT      = 8;
    localparam int REG_ADDR_WIDTH = 3;
    localparam int SCALE_WIDTH    = 5;    // Low bits of SCALE_ID used as shift

    // Registers the host may only read
    localparam logic [REG_COUNT-1:0] RTL_OWNED_MASK = 8'b1100_0000;

    typedef enum logic [REG_ADDR_WIDTH-1:0] {
        RST_ID        = 3'd0,
        DAC_HLT_ID    = 3'd1,
        BURST_SIZE_ID = 3'd2,
        SCALE_ID      = 3'd3,
        RUN_ID        = 3'd4,
        STEP_ID       = 3'd5,
        TS_STAMP_ID   = 3'd6,
        TS_VALID_ID   = 3'd7
    } reg_id_e;

    typedef struct packed {
        logic                      en;
        reg_id_e                   addr;
        logic [REG_DATA_WIDTH-1:0] data;
    } host_wr_t;

    typedef struct packed {
        logic                      en;
        reg_id_e                   addr;
        logic [REG_DATA_WIDTH-1:0] data;
    } rtl_wr_t;

    typedef struct packed {
        logic                      valid;
        logic [REG_DATA_WIDTH-1:0] stamp;
    } ts_req_t;

    typedef logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] batch_t;
    typedef logic [REG_COUNT-1:0][REG_DATA_WIDTH-1:0]   regs_t;

    typedef enum logic [2:0] {
        TS_IDLE,
        TS_WRITE_STAMP,
        TS_WRITE_VALID,
        TS_WAIT_READ,
        TS_CLEAR
    } ts_state_e;

    typedef enum logic [1:0] {
        RST_IDLE,
        RST_WAIT,
        RST_FIRE
    } rst_state_e;

endpackage

`default_nettype wire

// File: rtl/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank (
    input  wire                                clk,
    input  wire                                rst,
    input  wire sys_pkg::host_wr_t             host_wr,
    input  wire                                host_rd_en,
    input  wire sys_pkg::reg_id_e              host_rd_addr,
    output logic [sys_pkg::REG_DATA_WIDTH-1:0] host_rd_data,
    output logic                               host_rd_valid,
    input  wire sys_pkg::rtl_wr_t              rtl_wr,
    output sys_pkg::regs_t                     regs,
    output logic [sys_pkg::REG_COUNT-1:0]      fresh
);
    import sys_pkg::*;

    logic host_wr_ok;

    // Host may not touch the timestamp registers
    assign host_wr_ok = host_wr.en && !RTL_OWNED_MASK[host_wr.addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            regs          <= '0;
            fresh         <= '0;
            host_rd_valid <= 1'b0;
        end else begin
            host_rd_valid <= host_rd_en;
            if (host_rd_en) begin
                fresh[host_rd_addr] <= 1'b0;      // Consumed by host
            end
            // A write in the same cycle wins over the read clear
            if (host_wr_ok) begin
                regs[host_wr.addr]  <= host_wr.data;
                fresh[host_wr.addr] <= 1'b1;
            end
            if (rtl_wr.en) begin
                regs[rtl_wr.addr]  <= rtl_wr.data;  // Never the same address as host
                fresh[rtl_wr.addr] <= 1'b1;
            end
        end
    end

    // Read data returns the value before any write at the same edge
    always_ff @(posedge clk) begin
        if (host_rd_en) begin
            host_rd_data <= regs[host_rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: rtl/wave_gen.sv
`timescale 1ns/1ps
`default_nettype none

module wave_gen (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              start,
    input  wire [sys_pkg::SAMPLE_WIDTH-1:0]  base,
    input  wire [sys_pkg::SAMPLE_WIDTH-1:0]  step,
    input  wire                              dac_rdy,
    input  wire                              halt,
    output sys_pkg::batch_t                  batch,
    output logic                             batch_valid
);
    import sys_pkg::*;

    logic                    run;
    logic                    start_q;
    logic                    start_pulse;
    logic                    emit;
    logic [SAMPLE_WIDTH-1:0] value;       // First sample of the next batch
    logic [SAMPLE_WIDTH-1:0] value_next;
    batch_t                  batch_next;

    assign start_pulse = start && !start_q;   // RUN_ID just became fresh
    assign emit        = run && dac_rdy && !halt && !start_pulse;

    // Ramp out four samples, each one step above the last
    always_comb begin
        value_next = value;
        for (int k = 0; k < BATCH_SAMPLES; k++) begin
            batch_next[k] = value_next;
            value_next    = value_next + step;  // Wraps at 16 bits
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            run         <= 1'b0;
            start_q     <= 1'b0;
            batch_valid <= 1'b0;
        end else begin
            start_q     <= start;
            batch_valid <= emit;
            if (start_pulse) begin
                run <= 1'b1;                  // Restart takes priority over halt
            end else if (halt) begin
                run <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_pulse) begin
            value <= base;
        end else if (emit) begin
            value <= value_next;
        end
        if (emit) begin
            batch <= batch_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/ts_capture.sv
`timescale 1ns/1ps
`default_nettype none

module ts_capture (
    input  wire              clk,
    input  wire              rst,
    input  wire              trig,
    input  wire              ts_ack,
    output sys_pkg::ts_req_t ts_req
);
    import sys_pkg::*;

    logic [REG_DATA_WIDTH-1:0] count;       // Free-running cycle count
    logic                      held_valid;
    logic [REG_DATA_WIDTH-1:0] held_stamp;

    assign ts_req.valid = held_valid;
    assign ts_req.stamp = held_stamp;

    always_ff @(posedge clk) begin
        if (rst) begin
            count      <= '0;
            held_valid <= 1'b0;
        end else begin
            count <= count + 1'b1;
            if (held_valid) begin
                if (ts_ack) begin
                    held_valid <= 1'b0;         // Triggers while holding are dropped
                end
            end else if (trig) begin
                held_valid <= 1'b1;
            end
        end
    end

    // Stamp is the count seen at the trigger edge
    always_ff @(posedge clk) begin
        if (!held_valid && trig) begin
            held_stamp <= count;
        end
    end

endmodule

`default_nettype wire

// File: rtl/sys_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sys_ctrl (
    input  wire                           clk,
    input  wire                           rst,
    input  wire sys_pkg::regs_t           regs,
    input  wire [sys_pkg::REG_COUNT-1:0]  fresh,
    input  wire sys_pkg::batch_t          batch_raw,
    input  wire                           batch_raw_valid,
    input  wire sys_pkg::ts_req_t         ts_req,
    output logic                          ts_ack,
    output sys_pkg::rtl_wr_t              rtl_wr,
    output logic                          halt,
    output sys_pkg::batch_t               dac_batch,
    output logic                          dac_batch_valid,
    output logic                          sys_rst,
    output logic                          pl_rstn
);
    import sys_pkg::*;

    rst_state_e                rst_state;
    ts_state_e                 ts_state;
    logic                      rst_cmd;
    logic [SCALE_WIDTH-1:0]    scale;
    logic [REG_DATA_WIDTH-1:0] burst_size;
    logic [REG_DATA_WIDTH-1:0] burst_cnt;
    logic                      burst_last;
    logic                      run_fresh_q;
    logic                      run_start;
    logic                      hlt_fresh_q;
    logic                      hlt_pulse;

    assign sys_rst = rst || rst_cmd;
    assign pl_rstn = !sys_rst;

    assign burst_size = regs[BURST_SIZE_ID];
    assign run_start  = fresh[RUN_ID] && !run_fresh_q;
    assign burst_last = batch_raw_valid && (burst_size != '0) &&
                        (burst_cnt == burst_size - 1'b1);
    assign halt       = burst_last || hlt_pulse;

    assign dac_batch_valid = batch_raw_valid;

    always_comb begin
        for (int k = 0; k < BATCH_SAMPLES; k++) begin
            dac_batch[k] = batch_raw[k] >> scale;   // Logical shift
        end
    end

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            scale       <= '0;
            burst_cnt   <= '0;
            run_fresh_q <= 1'b0;
            hlt_fresh_q <= 1'b0;
            hlt_pulse   <= 1'b0;
        end else begin
            run_fresh_q <= fresh[RUN_ID];
            hlt_fresh_q <= fresh[DAC_HLT_ID];
            hlt_pulse   <= fresh[DAC_HLT_ID] && !hlt_fresh_q;
            if (fresh[SCALE_ID]) begin
                scale <= regs[SCALE_ID][SCALE_WIDTH-1:0];
            end
            if (run_start || hlt_pulse || burst_last) begin
                burst_cnt <= '0;              // New run or halted
            end else if (batch_raw_valid && burst_size != '0) begin
                burst_cnt <= burst_cnt + 1'b1;
            end
        end
    end

    // Reset command, fires three edges after the RST_ID write
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            rst_state <= RST_IDLE;
            rst_cmd   <= 1'b0;
        end else begin
            case (rst_state)
                RST_IDLE: if (fresh[RST_ID]) rst_state <= RST_WAIT;
                RST_WAIT: rst_state <= RST_FIRE;
                RST_FIRE: begin
                    rst_cmd   <= 1'b1;          // Clears itself through sys_rst
                    rst_state <= RST_IDLE;
                end
                default:  rst_state <= RST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            ts_state <= TS_IDLE;
        end else begin
            case (ts_state)
                TS_IDLE: begin
                    if (ts_req.valid && regs[TS_VALID_ID] == '0) ts_state <= TS_WRITE_STAMP;
                end
                TS_WRITE_STAMP: ts_state <= TS_WRITE_VALID;
                TS_WRITE_VALID: ts_state <= TS_WAIT_READ;
                TS_WAIT_READ: begin
                    if (!fresh[TS_STAMP_ID]) ts_state <= TS_CLEAR;  // Host has read it
                end
                default: ts_state <= TS_IDLE;
            endcase
        end
    end

    always_comb begin
        ts_ack      = 1'b0;
        rtl_wr.en   = 1'b0;
        rtl_wr.addr = TS_VALID_ID;
        rtl_wr.data = '0;
        case (ts_state)
            TS_WRITE_STAMP: begin
                ts_ack      = 1'b1;
                rtl_wr.en   = 1'b1;
                rtl_wr.addr = TS_STAMP_ID;
                rtl_wr.data = ts_req.stamp;
            end
            TS_WRITE_VALID: begin
                rtl_wr.en   = 1'b1;
                rtl_wr.data = 32'd1;
            end
            TS_CLEAR: rtl_wr.en = 1'b1;             // Valid back to 0
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/sys_top.sv
`timescale 1ns/1ps
`default_nettype none

module sys_top (
    input  wire                                clk,
    input  wire                                rst,
    input  wire sys_pkg::host_wr_t             host_wr,
    input  wire                                host_rd_en,
    input  wire sys_pkg::reg_id_e              host_rd_addr,
    output logic [sys_pkg::REG_DATA_WIDTH-1:0] host_rd_data,
    output logic                               host_rd_valid,
    input  wire                                dac_rdy,
    input  wire                                trig,
    output sys_pkg::batch_t                    dac_batch,
    output logic                               dac_batch_valid,
    output logic                               pl_rstn
);
    import sys_pkg::*;

    regs_t                regs;
    logic [REG_COUNT-1:0] fresh;
    rtl_wr_t              rtl_wr;
    ts_req_t              ts_req;
    logic                 ts_ack;
    logic                 halt;
    batch_t               batch_raw;
    logic                 batch_raw_valid;
    logic                 sys_rst;          // Board reset or host reset command

    reg_bank i_reg_bank (
        .clk           (clk),
        .rst           (sys_rst),
        .host_wr       (host_wr),
        .host_rd_en    (host_rd_en),
        .host_rd_addr  (host_rd_addr),
        .host_rd_data  (host_rd_data),
        .host_rd_valid (host_rd_valid),
        .rtl_wr        (rtl_wr),
        .regs          (regs),
        .fresh         (fresh)
    );

    wave_gen i_wave_gen (
        .clk         (clk),
        .rst         (sys_rst),
        .start       (fresh[RUN_ID]),
        .base        (regs[RUN_ID][SAMPLE_WIDTH-1:0]),
        .step        (regs[STEP_ID][SAMPLE_WIDTH-1:0]),
        .dac_rdy     (dac_rdy),
        .halt        (halt),
        .batch       (batch_raw),
        .batch_valid (batch_raw_valid)
    );

    ts_capture i_ts_capture (
        .clk    (clk),
        .rst    (sys_rst),
        .trig   (trig),
        .ts_ack (ts_ack),
        .ts_req (ts_req)
    );

    sys_ctrl i_sys_ctrl (
        .clk             (clk),
        .rst             (rst),
        .regs            (regs),
        .fresh           (fresh),
        .batch_raw       (batch_raw),
        .batch_raw_valid (batch_raw_valid),
        .ts_req          (ts_req),
        .ts_ack          (ts_ack),
        .rtl_wr          (rtl_wr),
        .halt            (halt),
        .dac_batch       (dac_batch),
        .dac_batch_valid (dac_batch_valid),
        .sys_rst         (sys_rst),
        .pl_rstn         (pl_rstn)
    );

endmodule

`default_nettype wire

// File: testbench/sys_assert.sv
`timescale 1ns/1ps
`default_nettype none

module sys_assert (
    input wire       clk,
    input wire       rst,
    input wire       halt,
    input wire       batch_raw_valid,
    input wire       hlt_fresh,
    input wire       rtl_wr_en,
    input wire [2:0] rtl_wr_addr,
    input wire       rd_en,
    input wire       rd_valid
);
    import sys_pkg::*;

    // Halt needs a batch in flight or a pending halt command
    a_halt_cause: assert property (@(posedge clk) disable iff (rst)
        halt |-> (batch_raw_valid || hlt_fresh))
        else $error("halt raised without a batch or a halt command");

    a_rtl_target: assert property (@(posedge clk) disable iff (rst)
        rtl_wr_en |-> (rtl_wr_addr == TS_STAMP_ID || rtl_wr_addr == TS_VALID_ID))
        else $error("RTL write outside the timestamp registers");

    a_rd_valid: assert property (@(posedge clk) disable iff (rst)
        ##1 (rd_valid == $past(rd_en)))
        else $error("host_rd_valid does not follow host_rd_en");

endmodule

bind sys_ctrl sys_assert i_sys_assert_ctrl (
    .clk             (clk),
    .rst             (sys_rst),
    .halt            (halt),
    .batch_raw_valid (batch_raw_valid),
    .hlt_fresh       (fresh[sys_pkg::DAC_HLT_ID]),
    .rtl_wr_en       (rtl_wr.en),
    .rtl_wr_addr     (rtl_wr.addr),
    .rd_en           (1'b0),
    .rd_valid        (1'b0)
);

bind reg_bank sys_assert i_sys_assert_bank (
    .clk             (clk),
    .rst             (rst),
    .halt            (1'b0),
    .batch_raw_valid (1'b0),
    .hlt_fresh       (1'b0),
    .rtl_wr_en       (1'b0),
    .rtl_wr_addr     (3'd6),
    .rd_en           (host_rd_en),
    .rd_valid        (host_rd_valid)
);

`default_nettype wire

// File: testbench/tb_sys_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sys_top;
    import sys_pkg::*;

    localparam int CLK_HALF    = 20;
    localparam int NUM_ROUNDS  = 6;
    localparam int ROUND_CYCLES = 400;
    localparam int RESET_ROUND = 2;

    logic                      clk = 1'b0;
    logic                      rst;
    host_wr_t                  host_wr;
    logic                      host_rd_en;
    reg_id_e                   host_rd_addr;
    logic [REG_DATA_WIDTH-1:0] host_rd_data;
    logic                      host_rd_valid;
    logic                      dac_rdy;
    logic                      trig;
    batch_t                    dac_batch;
    logic                      dac_batch_valid;
    logic                      pl_rstn;

    int                        err_cnt;
    int                        check_cnt;
    int                        batch_cnt;             // Valid batches since last run start
    int                        run_idx;               // Model ramp index
    logic [SAMPLE_WIDTH-1:0]   run_base;
    logic [SAMPLE_WIDTH-1:0]   run_step;
    int                        run_scale;
    logic [REG_DATA_WIDTH-1:0] model_count;           // Model of the timestamp counter
    logic [REG_DATA_WIDTH-1:0] exp_stamp;
    logic [REG_DATA_WIDTH-1:0] stamp_shadow;
    int                        rst_cd;                // Edges until reset command fires
    logic                      reset_now;

    sys_top i_sys_top (
        .clk             (clk),
        .rst             (rst),
        .host_wr         (host_wr),
        .host_rd_en      (host_rd_en),
        .host_rd_addr    (host_rd_addr),
        .host_rd_data    (host_rd_data),
        .host_rd_valid   (host_rd_valid),
        .dac_rdy         (dac_rdy),
        .trig            (trig),
        .dac_batch       (dac_batch),
        .dac_batch_valid (dac_batch_valid),
        .pl_rstn         (pl_rstn)
    );

    initial begin
        forever #(CLK_HALF) clk = ~clk;
    end

    initial begin
        #(CLK_HALF * 2 * (ROUND_CYCLES * NUM_ROUNDS + 10));
        $display("Watchdog expired before the test sequence completed");
        $display("STATUS: FAIL");
        $finish;
    end

    always @(negedge clk) begin
        dac_rdy <= ($urandom % 10) < 7;              // Random gaps on the DAC side
    end

    function automatic batch_t ramp_batch(input logic [SAMPLE_WIDTH-1:0] b,
                                          input logic [SAMPLE_WIDTH-1:0] s,
                                          input int idx, input int sh);
        batch_t                  r;
        logic [SAMPLE_WIDTH-1:0] v;
        for (int k = 0; k < BATCH_SAMPLES; k++) begin
            v    = b + s * (BATCH_SAMPLES * idx + k);
            r[k] = v >> sh;
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        err_cnt++;
        $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, exp_v, act_v);
    endtask

    task automatic report_error(input string what);
        err_cnt++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    // Reference model sampled at the rising edge before any update
    always @(posedge clk) begin
        reset_now = rst || (rst_cd == 1);
        check_cnt++;
        if (pl_rstn !== !reset_now) report_mismatch("pl_rstn", !reset_now, pl_rstn);
        if (dac_batch_valid === 1'b1) begin
            check_cnt++;
            if (dac_batch !== ramp_batch(run_base, run_step, run_idx, run_scale)) begin
                report_mismatch("dac_batch", ramp_batch(run_base, run_step, run_idx, run_scale),
                                dac_batch);
            end
            run_idx++;
            batch_cnt++;
        end
        if (trig) exp_stamp = model_count;
        if (rst_cd != 0) rst_cd--;
        if (host_wr.en && host_wr.addr == RST_ID && !reset_now) rst_cd = 4;
        model_count = reset_now ? '0 : model_count + 1'b1;
    end

    task automatic tick(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic write_reg(input reg_id_e id, input logic [REG_DATA_WIDTH-1:0] data);
        host_wr.en   = 1'b1;
        host_wr.addr = id;
        host_wr.data = data;
        @(negedge clk);
        host_wr.en   = 1'b0;
    endtask

    // Read data and its strobe arrive one cycle after the request
    task automatic read_reg(input reg_id_e id, output logic [REG_DATA_WIDTH-1:0] data);
        host_rd_en   = 1'b1;
        host_rd_addr = id;
        @(negedge clk);
        host_rd_en   = 1'b0;
        check_cnt++;
        if (host_rd_valid !== 1'b1) report_mismatch("host_rd_valid", 1'b1, host_rd_valid);
        data = host_rd_data;
    endtask

    task automatic expect_reg(input reg_id_e id, input logic [REG_DATA_WIDTH-1:0] exp_v);
        logic [REG_DATA_WIDTH-1:0] rd;
        read_reg(id, rd);
        check_cnt++;
        if (rd !== exp_v) report_mismatch({"host_rd_data ", id.name()}, exp_v, rd);
    endtask

    task automatic wait_batches(input int target, input int limit);
        int waited;
        waited = 0;
        while (batch_cnt < target && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (batch_cnt < target) report_error("generator stopped before the expected batches");
    endtask

    task automatic poll_ts_valid(input logic [REG_DATA_WIDTH-1:0] want);
        logic [REG_DATA_WIDTH-1:0] rd;
        int                        tries;
        tries = 0;
        rd    = ~want;
        while (rd !== want && tries < 30) begin
            read_reg(TS_VALID_ID, rd);
            tries++;
        end
        if (rd !== want) report_error("TS_VALID never reached the expected value");
    endtask

    task automatic capture_stamp();
        logic [REG_DATA_WIDTH-1:0] rd;
        tick($urandom % 7);
        trig = 1'b1;                                  // One-cycle trigger pulse
        @(negedge clk);
        trig = 1'b0;
        poll_ts_valid(32'd1);
        read_reg(TS_STAMP_ID, rd);
        check_cnt++;
        if (rd !== exp_stamp) report_mismatch("TS_STAMP", exp_stamp, rd);
        stamp_shadow = exp_stamp;
        poll_ts_valid(32'd0);
    endtask

    task automatic reset_command();
        int low_cnt;
        int first_low;
        low_cnt   = 0;
        first_low = -1;
        write_reg(RST_ID, $urandom);
        for (int i = 1; i <= 8; i++) begin
            @(negedge clk);
            if (!pl_rstn) begin
                low_cnt++;
                if (first_low < 0) first_low = i;
            end
        end
        check_cnt++;
        if (low_cnt != 1 || first_low > 5) report_error("pl_rstn pulse missing or misplaced");
        for (int r = 0; r < REG_COUNT; r++) begin
            expect_reg(reg_id_e'(r), '0);
        end
        stamp_shadow = '0;
    endtask

    task automatic run_round(input int round);
        logic [REG_DATA_WIDTH-1:0] step;
        logic [REG_DATA_WIDTH-1:0] base;
        logic [REG_DATA_WIDTH-1:0] scale;
        logic [REG_DATA_WIDTH-1:0] burst;
        int                        hold;
        step  = $urandom;
        base  = $urandom;
        scale = $urandom % 12;
        burst = ($urandom % 3 == 0) ? 0 : 1 + $urandom % 8;
        write_reg(STEP_ID, step);
        write_reg(SCALE_ID, scale);
        write_reg(BURST_SIZE_ID, burst);
        expect_reg(STEP_ID, step);
        expect_reg(SCALE_ID, scale);
        expect_reg(BURST_SIZE_ID, burst);
        write_reg(TS_STAMP_ID, $urandom);            // Host may not change these
        write_reg(TS_VALID_ID, $urandom);
        expect_reg(TS_STAMP_ID, stamp_shadow);
        expect_reg(TS_VALID_ID, '0);
        tick(4);
        run_base  = base[SAMPLE_WIDTH-1:0];
        run_step  = step[SAMPLE_WIDTH-1:0];
        run_scale = scale;
        run_idx   = 0;
        batch_cnt = 0;
        write_reg(RUN_ID, base);
        expect_reg(RUN_ID, base);                    // Also clears the fresh bit
        if (burst != 0) begin
            wait_batches(burst, 200);
            tick(30);
            check_cnt++;
            if (batch_cnt != burst) report_mismatch("batch count", burst, batch_cnt);
        end else begin
            wait_batches(6, 200);
            write_reg(DAC_HLT_ID, round);
            tick(5);
            hold = batch_cnt;
            tick(30);
            check_cnt++;
            if (batch_cnt != hold) report_mismatch("batch count after halt", hold, batch_cnt);
            expect_reg(DAC_HLT_ID, round);
        end
        capture_stamp();
        capture_stamp();                             // Second trigger captures again
        if (round == RESET_ROUND) begin
            reset_command();
            capture_stamp();                         // Counter restarted from zero
        end
    endtask

    initial begin
        void'($urandom(32'hf2a25121));
        err_cnt      = 0;
        check_cnt    = 0;
        batch_cnt    = 0;
        run_idx      = 0;
        run_base     = '0;
        run_step     = '0;
        run_scale    = 0;
        model_count  = '0;
        exp_stamp    = '0;
        stamp_shadow = '0;
        rst_cd       = 0;
        rst          = 1'b1;
        host_wr      = '0;
        host_rd_en   = 1'b0;
        host_rd_addr = RST_ID;
        dac_rdy      = 1'b0;
        trig         = 1'b0;
        tick(10);
        rst = 1'b0;
        tick(2);
        for (int round = 0; round < NUM_ROUNDS; round++) begin
            run_round(round);
        end
        tick(5);
        $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
rtl/sys_pkg.sv
rtl/reg_bank.sv
rtl/wave_gen.sv
rtl/ts_capture.sv
rtl/sys_ctrl.sv
rtl/sys_top.sv
testbench/sys_assert.sv
testbench/tb_sys_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then inspect the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_sys_top -f all.f > build.log 2>&1 \
    && ./obj_dir/Vtb_sys_top > sim.log 2>&1 \
    || echo "build or simulation did not complete" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log && exit 0 || exit 1
